//--- Bender.yml
package:
  name: rvvi_trace

dependencies: {}

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/trace_pkg.sv
      - design/rvfi_capture.sv
      - design/csr_track_slice.sv
      - design/net_event_gen.sv
      - design/trace_assemble.sv
      - design/rvvi_trace_top.sv

  - target: test
    include_dirs:
      - design
    files:
      - test/rvvi_trace_asserts.sv
      - test/tb_rvvi_trace.sv

//--- design/csr_track_slice.sv
/*
 * CSR tracking slice
 * Merges write data under the mask into read data and flags a changed value
 */
`timescale 1ns/10ps
`default_nettype none

module csr_track_slice (
   input  wire logic                 rvvi,
   input  wire logic                 rst_i,
   input  wire logic                 acc_valid_i,
   input  wire trace_pkg::csr_port_t csr_i,
   output trace_pkg::xlen_t          value_o,
   output logic                      changed_o
);

   import trace_pkg::*;

   xlen_t merged;

   // Written bits from wdata, untouched bits from rdata
   assign merged = (csr_i.wdata & csr_i.wmask) | (csr_i.rdata & ~csr_i.wmask);

   ////////////////////////////////////////////////////////////
   // Stored value and change flag
   ////////////////////////////////////////////////////////////
   always_ff @(posedge rvvi) begin
      if (rst_i) begin
         value_o   <= '0;
         changed_o <= 1'b0;
      end else if (acc_valid_i) begin
         // Compare against the value from the previous retirement
         changed_o <= (merged != value_o);
         value_o   <= merged;
      end else begin
         changed_o <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- design/net_event_gen.sv
/*
 * Net event generator
 * Derives NMI, fetch fault, interrupt and halt request levels plus a change pulse
 */
`timescale 1ns/10ps
`default_nettype none

`include "trace_config.svh"

module net_event_gen (
   input  wire logic                rvvi,
   input  wire logic                rst_i,
   input  wire logic                acc_valid_i,
   input  wire trace_pkg::retire_t  acc_rec_i,
   input  wire trace_pkg::irq_vec_t irq_i,
   input  wire logic                debug_req_i,
   output trace_pkg::net_state_t    net_o,
   output logic                     net_change_o
);

   import trace_pkg::*;

   net_state_t net_d;
   logic       nmi_hit;
   logic       fetch_fault;

   ////////////////////////////////////////////////////////////
   // Retirement-derived events
   ////////////////////////////////////////////////////////////

   // Data bus error taken as NMI, or NMI still pending at retirement
   assign nmi_hit =
      (acc_rec_i.intr && acc_rec_i.intr_interrupt &&
       ((acc_rec_i.intr_cause == intr_cause_t'(`TRACE_NMI_LOAD_CAUSE)) ||
        (acc_rec_i.intr_cause == intr_cause_t'(`TRACE_NMI_STORE_CAUSE)))) ||
      acc_rec_i.nmip[0];

   // Fetch bus error shows up as a synchronous exception
   assign fetch_fault = acc_rec_i.trap && acc_rec_i.trap_exception &&
                        (acc_rec_i.trap_exc_cause == exc_cause_t'(`TRACE_FETCH_FAULT_CAUSE));

   ////////////////////////////////////////////////////////////
   // Next net state
   ////////////////////////////////////////////////////////////
   always_comb begin
      net_d = net_o;
      // Pin levels follow every cycle
      net_d.irq     = irq_i;
      net_d.haltreq = debug_req_i;
      if (acc_valid_i) begin
         net_d.nmi        = nmi_hit;
         net_d.ibus_fault = fetch_fault;
         // Cause is kept after the NMI level drops
         if (nmi_hit) begin
            net_d.nmi_cause = acc_rec_i.intr_cause;
         end
      end
   end

   always_ff @(posedge rvvi) begin
      if (rst_i) begin
         net_o        <= '0;
         net_change_o <= 1'b0;
      end else begin
         net_o        <= net_d;
         net_change_o <= (net_d != net_o);
      end
   end

endmodule

`default_nettype wire

//--- design/rvfi_capture.sv
/*
 * Retirement capture stage
 * Accepts retirements with a new order number and registers them with the CSR ports
 */
`timescale 1ns/10ps
`default_nettype none

`include "trace_config.svh"

module rvfi_capture (
   input  wire logic                rvvi,
   input  wire logic                rst_i,
   input  wire logic                rvfi_valid_i,
   input  wire trace_pkg::retire_t  rvfi_i,
   input  wire trace_pkg::csr_port_t csr_i [`TRACE_NUM_CSR],
   output logic                     acc_valid_o,
   output trace_pkg::retire_t       acc_rec_o,
   output trace_pkg::csr_port_t     acc_csr_o [`TRACE_NUM_CSR]
);

   import trace_pkg::*;

   // Order number of the last accepted retirement
   order_t last_order;
   // Set once a retirement has been accepted since reset
   logic   have_order;
   logic   accept;

   ////////////////////////////////////////////////////////////
   // Acceptance
   ////////////////////////////////////////////////////////////

   // The port may show the same retirement for several cycles
   // First retirement after reset is taken whatever its order
   assign accept = rvfi_valid_i && (!have_order || (rvfi_i.order != last_order));

   always_ff @(posedge rvvi) begin
      if (rst_i) begin
         last_order  <= '0;
         have_order  <= 1'b0;
         acc_valid_o <= 1'b0;
      end else begin
         acc_valid_o <= accept;
         if (accept) begin
            last_order <= rvfi_i.order;
            have_order <= 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Payload capture
   ////////////////////////////////////////////////////////////

   // Payload only loads on accept, qualified downstream by acc_valid_o
   always_ff @(posedge rvvi) begin
      if (accept) begin
         acc_rec_o <= rvfi_i;
      end
   end

   // CSR views sampled on the same edge as the retirement
   always_ff @(posedge rvvi) begin
      if (accept) begin
         for (int i = 0; i < `TRACE_NUM_CSR; i++) begin
            acc_csr_o[i] <= csr_i[i];
         end
      end
   end

endmodule

`default_nettype wire

//--- design/rvvi_trace_top.sv
/*
 * Retirement trace converter top
 * Formal-interface retirements in, registered verification-interface record out
 */
`timescale 1ns/10ps
`default_nettype none

`include "trace_config.svh"

module rvvi_trace_top (
   input  wire logic                 rvvi,
   input  wire logic                 rst_i,
   input  wire logic                 rvfi_valid_i,
   input  wire trace_pkg::retire_t   rvfi_i,
   input  wire trace_pkg::csr_port_t csr_i [`TRACE_NUM_CSR],
   input  wire trace_pkg::irq_vec_t  irq_i,
   input  wire logic                 debug_req_i,
   output logic                      trace_valid_o,
   output trace_pkg::trace_rec_t     trace_o,
   output trace_pkg::xlen_t          csr_value_o [`TRACE_NUM_CSR],
   output trace_pkg::csr_mask_t      csr_wb_o,
   output trace_pkg::reg_mask_t      x_wb_o,
   output trace_pkg::xlen_t          x_wdata_o,
   output trace_pkg::net_state_t     net_o,
   output logic                      net_change_o
);

   import trace_pkg::*;

   // Stage one outputs
   logic      acc_valid;
   retire_t   acc_rec;
   csr_port_t acc_csr [`TRACE_NUM_CSR];

   // Slice results
   xlen_t     slice_value [`TRACE_NUM_CSR];
   csr_mask_t slice_changed;

   rvfi_capture u_rvfi_capture (
      .rvvi         (rvvi),
      .rst_i        (rst_i),
      .rvfi_valid_i (rvfi_valid_i),
      .rvfi_i       (rvfi_i),
      .csr_i        (csr_i),
      .acc_valid_o  (acc_valid),
      .acc_rec_o    (acc_rec),
      .acc_csr_o    (acc_csr)
   );

   ////////////////////////////////////////////////////////////
   // One tracking slice per CSR slot
   ////////////////////////////////////////////////////////////
   for (genvar gi = 0; gi < `TRACE_NUM_CSR; gi++) begin : g_slice
      csr_track_slice u_csr_track_slice (
         .rvvi        (rvvi),
         .rst_i       (rst_i),
         .acc_valid_i (acc_valid),
         .csr_i       (acc_csr[gi]),
         .value_o     (slice_value[gi]),
         .changed_o   (slice_changed[gi])
      );
   end

   net_event_gen u_net_event_gen (
      .rvvi         (rvvi),
      .rst_i        (rst_i),
      .acc_valid_i  (acc_valid),
      .acc_rec_i    (acc_rec),
      .irq_i        (irq_i),
      .debug_req_i  (debug_req_i),
      .net_o        (net_o),
      .net_change_o (net_change_o)
   );

   trace_assemble u_trace_assemble (
      .rvvi            (rvvi),
      .rst_i           (rst_i),
      .acc_valid_i     (acc_valid),
      .acc_rec_i       (acc_rec),
      .slice_value_i   (slice_value),
      .slice_changed_i (slice_changed),
      .trace_valid_o   (trace_valid_o),
      .trace_o         (trace_o),
      .csr_value_o     (csr_value_o),
      .csr_wb_o        (csr_wb_o),
      .x_wb_o          (x_wb_o),
      .x_wdata_o       (x_wdata_o)
   );

endmodule

`default_nettype wire

//--- design/trace_assemble.sv
/*
 * Trace record assembly
 * Registers the output record and decodes the register write-back
 */
`timescale 1ns/10ps
`default_nettype none

`include "trace_config.svh"

module trace_assemble (
   input  wire logic                 rvvi,
   input  wire logic                 rst_i,
   input  wire logic                 acc_valid_i,
   input  wire trace_pkg::retire_t   acc_rec_i,
   input  wire trace_pkg::xlen_t     slice_value_i [`TRACE_NUM_CSR],
   input  wire trace_pkg::csr_mask_t slice_changed_i,
   output logic                      trace_valid_o,
   output trace_pkg::trace_rec_t     trace_o,
   output trace_pkg::xlen_t          csr_value_o [`TRACE_NUM_CSR],
   output trace_pkg::csr_mask_t      csr_wb_o,
   output trace_pkg::reg_mask_t      x_wb_o,
   output trace_pkg::xlen_t          x_wdata_o
);

   import trace_pkg::*;

   // One-hot of the destination register, x0 never written
   function automatic reg_mask_t rd_onehot(input reg_addr_t addr);
      reg_mask_t mask;
      mask    = reg_mask_t'(1) << addr;
      mask[0] = 1'b0;
      return mask;
   endfunction

   ////////////////////////////////////////////////////////////
   // Control outputs
   ////////////////////////////////////////////////////////////
   always_ff @(posedge rvvi) begin
      if (rst_i) begin
         trace_valid_o <= 1'b0;
         x_wb_o        <= '0;
      end else begin
         trace_valid_o <= acc_valid_i;
         x_wb_o        <= acc_valid_i ? rd_onehot(acc_rec_i.rd_addr) : '0;
      end
   end

   ////////////////////////////////////////////////////////////
   // Record payload
   ////////////////////////////////////////////////////////////
   always_ff @(posedge rvvi) begin
      if (acc_valid_i) begin
         trace_o.order    <= acc_rec_i.order;
         trace_o.insn     <= acc_rec_i.insn;
         trace_o.pc_rdata <= acc_rec_i.pc_rdata;
         trace_o.pc_wdata <= acc_rec_i.pc_wdata;
         trace_o.mode     <= acc_rec_i.mode;
         trace_o.ixl      <= acc_rec_i.ixl;
         trace_o.trap     <= acc_rec_i.trap;
         trace_o.intr     <= acc_rec_i.intr;
         x_wdata_o        <= acc_rec_i.rd_wdata;
      end
   end

   // Slices register on the same edge as the record
   assign csr_value_o = slice_value_i;
   assign csr_wb_o    = slice_changed_i;

endmodule

`default_nettype wire

//--- design/trace_config.svh
/*
 * Trace converter configuration
 * Data widths, CSR slot map and the cause codes that mark NMI and bus faults
 */
`ifndef TRACE_CONFIG_SVH
`define TRACE_CONFIG_SVH

// Datapath and slot sizes
`define TRACE_XLEN              32
`define TRACE_NUM_CSR           8
`define TRACE_NUM_IRQ           32

////////////////////////////////////////////////////////////
// CSR slot map, slot index to architectural address
////////////////////////////////////////////////////////////
`define TRACE_CSR_ADDR_0        12'h300
`define TRACE_CSR_ADDR_1        12'h304
`define TRACE_CSR_ADDR_2        12'h305
`define TRACE_CSR_ADDR_3        12'h340
`define TRACE_CSR_ADDR_4        12'h341
`define TRACE_CSR_ADDR_5        12'h342
`define TRACE_CSR_ADDR_6        12'h343
`define TRACE_CSR_ADDR_7        12'h344

////////////////////////////////////////////////////////////
// Cause codes seen on the retirement port
////////////////////////////////////////////////////////////
// Data bus errors reported as NMI
`define TRACE_NMI_LOAD_CAUSE    1024
`define TRACE_NMI_STORE_CAUSE   1025
// Instruction fetch bus error, reported as a trap
`define TRACE_FETCH_FAULT_CAUSE 24

`endif

//--- design/trace_pkg.sv
/*
 * Trace types package
 * Field widths and the structs passed between the converter stages
 */
`default_nettype none

`include "trace_config.svh"

package trace_pkg;

   // Plain vector types with a meaning of their own
   typedef logic [`TRACE_XLEN-1:0]    xlen_t;
   typedef logic [63:0]               order_t;
   typedef logic [4:0]                reg_addr_t;
   typedef logic [31:0]               reg_mask_t;
   typedef logic [5:0]                exc_cause_t;
   typedef logic [10:0]               intr_cause_t;
   typedef logic [`TRACE_NUM_IRQ-1:0] irq_vec_t;
   typedef logic [`TRACE_NUM_CSR-1:0] csr_mask_t;

   ////////////////////////////////////////////////////////////
   // One retired instruction as seen on the formal port
   ////////////////////////////////////////////////////////////
   typedef struct packed {
      order_t      order;
      xlen_t       insn;
      xlen_t       pc_rdata;
      xlen_t       pc_wdata;
      logic [1:0]  mode;
      logic [1:0]  ixl;
      logic        trap;
      logic        trap_exception;
      exc_cause_t  trap_exc_cause;
      logic        intr;
      logic        intr_interrupt;
      intr_cause_t intr_cause;
      logic [1:0]  nmip;
      reg_addr_t   rd_addr;
      xlen_t       rd_wdata;
   } retire_t;

   // CSR view of one slot, read value plus masked write
   typedef struct packed {
      xlen_t rdata;
      xlen_t wdata;
      xlen_t wmask;
   } csr_port_t;

   // Instruction part of the output record
   typedef struct packed {
      order_t     order;
      xlen_t      insn;
      xlen_t      pc_rdata;
      xlen_t      pc_wdata;
      logic [1:0] mode;
      logic [1:0] ixl;
      logic       trap;
      logic       intr;
   } trace_rec_t;

   // Asynchronous net levels
   typedef struct packed {
      logic        nmi;
      intr_cause_t nmi_cause;
      logic        ibus_fault;
      irq_vec_t    irq;
      logic        haltreq;
   } net_state_t;

endpackage

`default_nettype wire

//--- project.f
+incdir+design
design/trace_pkg.sv
design/rvfi_capture.sv
design/csr_track_slice.sv
design/net_event_gen.sv
design/trace_assemble.sv
design/rvvi_trace_top.sv
test/rvvi_trace_asserts.sv
test/tb_rvvi_trace.sv

//--- test/rvvi_trace_asserts.sv
/*
 * Trace converter assertions
 * Record timing and write-back mask rules, bound to the top level
 */
`timescale 1ns/10ps
`default_nettype none

module rvvi_trace_asserts (
   input wire logic                 rvvi,
   input wire logic                 rst_i,
   input wire logic                 rvfi_valid_i,
   input wire trace_pkg::order_t    rvfi_order_i,
   input wire logic                 trace_valid_i,
   input wire trace_pkg::csr_mask_t csr_wb_i,
   input wire trace_pkg::reg_mask_t x_wb_i
);

   import trace_pkg::*;

   // Failed assertions so far
   int     num_fails;
   // Last order number taken at the port
   order_t seen_order;
   logic   seen_valid;
   logic   new_ret;

   ////////////////////////////////////////////////////////////
   // Record timing
   ////////////////////////////////////////////////////////////

   // A retirement with a new order number, seen at the port
   assign new_ret = rvfi_valid_i && (!seen_valid || (rvfi_order_i != seen_order));

   always_ff @(posedge rvvi) begin
      if (rst_i) begin
         seen_order <= '0;
         seen_valid <= 1'b0;
      end else if (new_ret) begin
         seen_order <= rvfi_order_i;
         seen_valid <= 1'b1;
      end
   end

   // Sampled at the port, captured on that edge, record on the second edge after
   a_trace_follows_accept: assert property (
      @(posedge rvvi) disable iff (rst_i) new_ret |-> ##2 trace_valid_i
   ) else begin
      num_fails++;
      $error("trace valid missing two edges after an accepted retirement");
   end

   a_no_stray_trace: assert property (
      @(posedge rvvi) disable iff (rst_i) trace_valid_i |-> $past(new_ret, 2)
   ) else begin
      num_fails++;
      $error("trace valid without an accepted retirement");
   end

   ////////////////////////////////////////////////////////////
   // Write-back masks
   ////////////////////////////////////////////////////////////
   a_xwb_onehot: assert property (
      @(posedge rvvi) disable iff (rst_i) $onehot0(x_wb_i) && !x_wb_i[0]
   ) else begin
      num_fails++;
      $error("register write-back mask not one-hot or x0 written");
   end

   a_csr_wb_idle: assert property (
      @(posedge rvvi) disable iff (rst_i) !trace_valid_i |-> (csr_wb_i == '0)
   ) else begin
      num_fails++;
      $error("CSR write-back flag set without a record");
   end

endmodule

`default_nettype wire

//--- test/tb_rvvi_trace.sv
/*
 * Trace converter testbench
 * Replays retirement cases from a file against a reference model of the record
 */
`timescale 1ns/10ps
`default_nettype none

`include "trace_config.svh"

module tb_rvvi_trace;

   import trace_pkg::*;

   localparam int MAX_ROWS    = 64;
   localparam int HALF_PERIOD = 20;

   // One line of the case file plus its random fillers
   typedef struct packed {
      logic [3:0]  test;
      logic        valid;
      retire_t     rec;
      logic [2:0]  slot;
      xlen_t       wdata;
      xlen_t       wmask;
      irq_vec_t    irq;
      logic        dbg;
      logic        nmi;
      intr_cause_t nmi_cause;
      logic        fault;
   } case_t;

   logic       rvvi;
   logic       rst_i;
   logic       rvfi_valid_i;
   retire_t    rvfi_i;
   csr_port_t  csr_i [`TRACE_NUM_CSR];
   irq_vec_t   irq_i;
   logic       debug_req_i;
   logic       trace_valid_o;
   trace_rec_t trace_o;
   xlen_t      csr_value_o [`TRACE_NUM_CSR];
   csr_mask_t  csr_wb_o;
   reg_mask_t  x_wb_o;
   xlen_t      x_wdata_o;
   net_state_t net_o;
   logic       net_change_o;

   case_t      rows [MAX_ROWS];
   int         num_cases;
   int         num_rows;

   // Expected record side, captured when a row is driven
   logic       exp_acc [MAX_ROWS];
   xlen_t      exp_csr [MAX_ROWS][`TRACE_NUM_CSR];
   csr_mask_t  exp_wb [MAX_ROWS];
   reg_mask_t  exp_xwb [MAX_ROWS];
   xlen_t      exp_xwdata [MAX_ROWS];

   // Reference model state
   logic [31:0] rng;
   order_t      last_order;
   logic        have_order;
   xlen_t       arch_csr [`TRACE_NUM_CSR];
   xlen_t       model_csr [`TRACE_NUM_CSR];
   xlen_t       model_xwdata;
   net_state_t  model_net;

   int cur_test;
   int test_errors [16];
   int tests_done;
   int num_checks;
   int num_errors;

   always #(HALF_PERIOD) rvvi = ~rvvi;

   rvvi_trace_top u_rvvi_trace_top (
      .rvvi          (rvvi),
      .rst_i         (rst_i),
      .rvfi_valid_i  (rvfi_valid_i),
      .rvfi_i        (rvfi_i),
      .csr_i         (csr_i),
      .irq_i         (irq_i),
      .debug_req_i   (debug_req_i),
      .trace_valid_o (trace_valid_o),
      .trace_o       (trace_o),
      .csr_value_o   (csr_value_o),
      .csr_wb_o      (csr_wb_o),
      .x_wb_o        (x_wb_o),
      .x_wdata_o     (x_wdata_o),
      .net_o         (net_o),
      .net_change_o  (net_change_o)
   );

   bind rvvi_trace_top rvvi_trace_asserts u_rvvi_trace_asserts (
      .rvvi          (rvvi),
      .rst_i         (rst_i),
      .rvfi_valid_i  (rvfi_valid_i),
      .rvfi_order_i  (rvfi_i.order),
      .trace_valid_i (trace_valid_o),
      .csr_wb_i      (csr_wb_o),
      .x_wb_i        (x_wb_o)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Instruction fields copied into the output record
   function automatic trace_rec_t record_of(input retire_t r);
      trace_rec_t t;
      t.order    = r.order;
      t.insn     = r.insn;
      t.pc_rdata = r.pc_rdata;
      t.pc_wdata = r.pc_wdata;
      t.mode     = r.mode;
      t.ixl      = r.ixl;
      t.trap     = r.trap;
      t.intr     = r.intr;
      return t;
   endfunction

   function automatic string test_name(input int t);
      case (t)
         1:       return "order and valid";
         2:       return "CSR merge";
         3:       return "register write-back";
         4:       return "NMI";
         5:       return "fetch fault";
         6:       return "irq and halt request";
         default: return "unnamed";
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // Case file
   ////////////////////////////////////////////////////////////
   task automatic load_cases();
      int          fd;
      int          n;
      int          j;
      string       line;
      logic [63:0] f [19];
      case_t       c;
      num_cases = 0;
      fd = $fopen("test/trace_cases.txt", "r");
      if (fd != 0) begin
         while (!$feof(fd) && num_cases < MAX_ROWS - 2) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 1 && line.getc(0) != "#") begin
               n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                           f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18]);
               if (n == 19) begin
                  c = '0;
                  c.test                   = f[0][3:0];
                  c.valid                  = f[1][0];
                  c.rec.order              = f[2];
                  c.rec.insn               = f[3][31:0];
                  c.rec.rd_addr            = f[4][4:0];
                  c.rec.rd_wdata           = f[5][31:0];
                  c.rec.trap               = f[6][0];
                  c.rec.trap_exception     = f[6][0];
                  c.rec.trap_exc_cause     = f[7][5:0];
                  c.rec.intr               = f[8][0];
                  c.rec.intr_interrupt     = f[8][0];
                  c.rec.intr_cause         = f[9][10:0];
                  c.rec.nmip               = f[10][1:0];
                  c.irq                    = f[11][31:0];
                  c.dbg                    = f[12][0];
                  c.slot                   = f[13][2:0];
                  c.wdata                  = f[14][31:0];
                  c.wmask                  = f[15][31:0];
                  c.nmi                    = f[16][0];
                  c.nmi_cause              = f[17][10:0];
                  c.fault                  = f[18][0];
                  // Filler fields
                  rng                      = xorshift32(rng);
                  c.rec.pc_rdata           = {rng[31:2], 2'b00};
                  c.rec.pc_wdata           = c.rec.pc_rdata + 32'd4;
                  rng                      = xorshift32(rng);
                  c.rec.mode               = rng[1:0];
                  c.rec.ixl                = rng[3:2];
                  rows[num_cases]          = c;
                  num_cases++;
               end
            end
         end
         $fclose(fd);
      end
      // Two idle rows drain the pipeline
      for (j = 0; j < 2; j++) begin
         c      = '0;
         c.test = (num_cases > 0) ? rows[num_cases-1].test : 4'd0;
         rows[num_cases + j] = c;
      end
      num_rows = num_cases + 2;
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus and reference model
   ////////////////////////////////////////////////////////////
   task automatic drive_row(input int i);
      int        s;
      logic      acc;
      csr_port_t port;
      xlen_t     merged;
      rvfi_valid_i <= rows[i].valid;
      rvfi_i       <= rows[i].rec;
      irq_i        <= rows[i].irq;
      debug_req_i  <= rows[i].dbg;
      acc = rows[i].valid && (!have_order || rows[i].rec.order != last_order);
      if (acc) begin
         last_order = rows[i].rec.order;
         have_order = 1'b1;
         model_xwdata = rows[i].rec.rd_wdata;
      end
      exp_wb[i] = '0;
      for (s = 0; s < `TRACE_NUM_CSR; s++) begin
         port.rdata = arch_csr[s];
         if (s == int'(rows[i].slot)) begin
            port.wdata = rows[i].wdata;
            port.wmask = rows[i].wmask;
         end else begin
            // Unwritten slots carry noise under an empty mask
            rng = xorshift32(rng);
            port.wdata = rng;
            port.wmask = '0;
         end
         csr_i[s] <= port;
         merged = (port.rdata & ~port.wmask) | (port.wdata & port.wmask);
         if (acc) begin
            exp_wb[i][s] = (merged != model_csr[s]);
            model_csr[s] = merged;
            arch_csr[s]  = merged;
         end
         exp_csr[i][s] = model_csr[s];
      end
      exp_acc[i] = acc;
      exp_xwb[i] = '0;
      if (acc && rows[i].rec.rd_addr != 5'd0) begin
         exp_xwb[i][rows[i].rec.rd_addr] = 1'b1;
      end
      exp_xwdata[i] = model_xwdata;
   endtask

   ////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////
   task automatic report_error(input string msg);
      num_errors++;
      test_errors[cur_test]++;
      $display("[ERROR] %0t %s", $time, msg);
   endtask

   task automatic check_trace(input logic exp_valid, input trace_rec_t exp);
      num_checks++;
      if (trace_valid_o !== exp_valid) begin
         report_error($sformatf("trace_valid_o is %b, expected %b", trace_valid_o, exp_valid));
      end else if (exp_valid && trace_o !== exp) begin
         report_error($sformatf("trace_o is %h, expected %h", trace_o, exp));
      end
   endtask

   task automatic check_csr(input int slot, input xlen_t exp_value, input csr_mask_t exp_wb);
      num_checks++;
      if (csr_value_o[slot] !== exp_value || csr_wb_o[slot] !== exp_wb[slot]) begin
         report_error($sformatf("CSR slot %0d value %h wb %b, expected %h wb %b", slot,
                                csr_value_o[slot], csr_wb_o[slot], exp_value, exp_wb[slot]));
      end
   endtask

   task automatic check_xwb(input reg_mask_t exp_mask, input xlen_t exp_data);
      num_checks++;
      if (x_wb_o !== exp_mask || x_wdata_o !== exp_data) begin
         report_error($sformatf("x_wb_o %h data %h, expected %h data %h",
                                x_wb_o, x_wdata_o, exp_mask, exp_data));
      end
   endtask

   task automatic check_net(input net_state_t exp, input logic exp_change);
      num_checks++;
      if (net_o !== exp || net_change_o !== exp_change) begin
         report_error($sformatf("net_o %h change %b, expected %h change %b",
                                net_o, net_change_o, exp, exp_change));
      end
   endtask

   task automatic finish_test(input int t);
      tests_done++;
      if (test_errors[t] == 0) begin
         $display("Test %0d (%s) done, no errors", t, test_name(t));
      end else begin
         $display("Test %0d (%s) done, %0d errors", t, test_name(t), test_errors[t]);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Sequencing
   ////////////////////////////////////////////////////////////
   task automatic run_cases();
      int         i;
      int         k;
      int         s;
      net_state_t prev_net;
      for (i = 0; i < num_rows; i++) begin
         @(posedge rvvi);
         drive_row(i);
         @(negedge rvvi);
         // Pins of the previous row, retirement effects of the row two back
         prev_net = model_net;
         if (i >= 2 && exp_acc[i-2]) begin
            model_net.nmi        = rows[i-2].nmi;
            model_net.nmi_cause  = rows[i-2].nmi_cause;
            model_net.ibus_fault = rows[i-2].fault;
         end
         if (i >= 1) begin
            model_net.irq     = rows[i-1].irq;
            model_net.haltreq = rows[i-1].dbg;
         end
         cur_test = (i >= 1) ? int'(rows[i-1].test) : int'(rows[0].test);
         check_net(model_net, model_net != prev_net);
         if (i >= 2 && i - 2 < num_cases) begin
            k = i - 2;
            cur_test = rows[k].test;
            check_trace(exp_acc[k], record_of(rows[k].rec));
            for (s = 0; s < `TRACE_NUM_CSR; s++) begin
               check_csr(s, exp_csr[k][s], exp_wb[k]);
            end
            check_xwb(exp_xwb[k], exp_xwdata[k]);
            if (k == num_cases - 1 || rows[k+1].test != rows[k].test) begin
               finish_test(rows[k].test);
            end
         end
      end
   endtask

   task automatic finish_run();
      int assert_fails;
      assert_fails = u_rvvi_trace_top.u_rvvi_trace_asserts.num_fails;
      $display("Tests %0d, checks %0d, errors %0d, assertion failures %0d",
               tests_done, num_checks, num_errors, assert_fails);
      if (num_errors == 0 && assert_fails == 0 && tests_done > 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   endtask

   initial begin
      rvvi         = 1'b0;
      rst_i        = 1'b1;
      rvfi_valid_i = 1'b0;
      rvfi_i       = '0;
      irq_i        = '0;
      debug_req_i  = 1'b0;
      rng          = 32'h4f28_915c;
      last_order   = '0;
      have_order   = 1'b0;
      model_xwdata = '0;
      model_net    = '0;
      for (int s = 0; s < `TRACE_NUM_CSR; s++) begin
         csr_i[s]     = '0;
         model_csr[s] = '0;
         rng          = xorshift32(rng);
         arch_csr[s]  = rng;
      end
      load_cases();
      if (num_cases == 0) begin
         $display("No cases could be read from test/trace_cases.txt");
         $display("=== FAIL ===");
         $finish;
      end else begin
         repeat (10) @(posedge rvvi);
         rst_i <= 1'b0;
         run_cases();
         finish_run();
      end
   end

   // Watchdog sized from the case count
   initial begin
      wait (num_cases > 0);
      repeat (num_cases * 4 + 200) @(posedge rvvi);
      $display("Timeout, run still going after %0d cycles", num_cases * 4 + 200);
      $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

//--- test/trace_cases.txt
# Columns, all hex: test valid order insn rd rd_wdata trap exc_cause intr intr_cause nmip
#   irq debug_req csr_slot csr_wdata csr_wmask exp_nmi exp_nmi_cause exp_ibus_fault
1 1 10 00000013 01 00000001 0 00 0 000 0 00000000 0 0 00000000 00000000 0 000 0
1 1 11 00100093 01 00000002 0 00 0 000 0 00000000 0 0 00000000 00000000 0 000 0
1 1 11 00100093 01 00000002 0 00 0 000 0 00000000 0 0 00000000 00000000 0 000 0
1 0 12 00208113 02 00000004 0 00 0 000 0 00000000 0 0 00000000 00000000 0 000 0
1 1 12 00208113 02 00000004 0 00 0 000 0 00000000 0 0 00000000 00000000 0 000 0
1 1 13 00310193 03 00000007 0 00 0 000 0 00000000 0 0 00000000 00000000 0 000 0
2 1 20 30029073 00 00000000 0 00 0 000 0 00000000 0 0 00001888 00001888 0 000 0
2 1 21 30429073 00 00000000 0 00 0 000 0 00000000 0 1 ffffffff 0000ffff 0 000 0
2 1 22 00000013 00 00000000 0 00 0 000 0 00000000 0 5 12345678 00000000 0 000 0
2 1 23 34229073 00 00000000 0 00 0 000 0 00000000 0 5 8000000b ffffffff 0 000 0
2 1 24 34029073 00 00000000 0 00 0 000 0 00000000 0 3 a5a5a5a5 ffffffff 0 000 0
2 1 25 34029073 00 00000000 0 00 0 000 0 00000000 0 3 a5a5a5a5 ffffffff 0 000 0
2 1 26 34429073 00 00000000 0 00 0 000 0 00000000 0 7 00000880 00000088 0 000 0
2 1 26 34429073 00 00000000 0 00 0 000 0 00000000 0 7 ffffffff ffffffff 0 000 0
3 1 30 00100093 01 11111111 0 00 0 000 0 00000000 0 0 00000000 00000000 0 000 0
3 1 31 00000f93 1f deadbeef 0 00 0 000 0 00000000 0 0 00000000 00000000 0 000 0
3 1 32 00000013 00 12345678 0 00 0 000 0 00000000 0 0 00000000 00000000 0 000 0
3 1 33 00a00513 0a 0000cafe 0 00 0 000 0 00000000 0 0 00000000 00000000 0 000 0
4 1 40 00000013 00 00000000 0 00 1 400 0 00000000 0 0 00000000 00000000 1 400 0
4 1 41 00000013 00 00000000 0 00 0 000 0 00000000 0 0 00000000 00000000 0 400 0
4 1 42 00000013 00 00000000 0 00 1 401 0 00000000 0 0 00000000 00000000 1 401 0
4 1 43 00000013 00 00000000 0 00 1 007 0 00000000 0 0 00000000 00000000 0 401 0
4 1 44 00000013 00 00000000 0 00 0 400 1 00000000 0 0 00000000 00000000 1 400 0
4 1 45 00000013 00 00000000 0 00 0 000 0 00000000 0 0 00000000 00000000 0 400 0
4 1 45 00000013 00 00000000 0 00 1 401 0 00000000 0 0 00000000 00000000 0 400 0
5 1 50 00000013 00 00000000 1 18 0 000 0 00000000 0 0 00000000 00000000 0 400 1
5 1 51 00000013 00 00000000 0 00 0 000 0 00000000 0 0 00000000 00000000 0 400 0
5 1 52 00000013 00 00000000 1 02 0 000 0 00000000 0 0 00000000 00000000 0 400 0
5 1 53 00000013 00 00000000 1 18 0 000 0 00000000 0 0 00000000 00000000 0 400 1
5 1 54 00000013 00 00000000 0 00 0 000 0 00000000 0 0 00000000 00000000 0 400 0
6 0 54 00000013 00 00000000 0 00 0 000 0 00000001 0 0 00000000 00000000 0 400 0
6 0 54 00000013 00 00000000 0 00 0 000 0 00000001 0 0 00000000 00000000 0 400 0
6 0 54 00000013 00 00000000 0 00 0 000 0 80000001 1 0 00000000 00000000 0 400 0
6 1 60 00000013 00 00000000 0 00 0 000 0 80000001 1 0 00000000 00000000 0 400 0
6 0 60 00000013 00 00000000 0 00 0 000 0 00000000 0 0 00000000 00000000 0 400 0
6 0 60 00000013 00 00000000 0 00 0 000 0 00000000 0 0 00000000 00000000 0 400 0
